//--- Bender.yml
package:
  name: rv32i_core

sources:
  - rtl/core_pkg.sv
  - rtl/decoded_if.sv
  - rtl/instr_decode.sv
  - rtl/reg_file.sv
  - rtl/exec_unit.sv
  - rtl/core_sequencer.sv
  - rtl/core_top.sv
  - target: simulation
    files:
      - tb/tb_mem.sv
      - tb/tb_core.sv

//--- build.f
rtl/core_pkg.sv
rtl/decoded_if.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/core_sequencer.sv
rtl/core_top.sv
tb/tb_mem.sv
tb/tb_core.sv

//--- rtl/core_pkg.sv
// widths, encodings and special store addresses shared by every rv32i core module
`default_nettype none

package core_pkg;

    // datapath sizes
    localparam int data_width    = 32;
    localparam int addr_width    = 32;
    localparam int reg_sel_width = 5;
    localparam int num_regs      = 32;

    // first instruction fetched after reset
    localparam logic [addr_width-1:0] reset_pc = 32'd128;

    // stores to these never reach memory
    // one drives the output port, the other stops the core
    localparam logic [addr_width-1:0] out_addr  = 32'd1000000;
    localparam logic [addr_width-1:0] halt_addr = 32'd1000004;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPIMM  = 7'b0010011,
        OP     = 7'b0110011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111
    } opcode_e;

    // alu functions picked from funct3/funct7
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        // lui only, result is the immediate
        ALU_PASS
    } alu_op_e;

    // one instruction in flight, no overlap
    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM,
        HALTED
    } seq_state_e;

endpackage

`default_nettype wire

//--- rtl/core_sequencer.sv
// fetch/exec/mem state machine: holds pc and instruction, runs the memory port and write-back
`timescale 1ns/1ps
`default_nettype none

module core_sequencer (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               ena,
    input  logic [core_pkg::data_width-1:0]    mem_rd_data,
    input  logic                               mem_ack,
    input  logic [core_pkg::data_width-1:0]    result,
    input  logic [core_pkg::addr_width-1:0]    next_pc,
    input  logic [core_pkg::addr_width-1:0]    mem_addr_calc,
    input  logic [core_pkg::data_width-1:0]    rs2_data,
    decoded_if.seq                             dec,
    output logic [core_pkg::addr_width-1:0]    pc,
    output logic [core_pkg::data_width-1:0]    instr,
    output logic                               rf_wr_en,
    output logic [core_pkg::reg_sel_width-1:0] rf_wr_sel,
    output logic [core_pkg::data_width-1:0]    rf_wr_data,
    output logic [core_pkg::addr_width-1:0]    mem_addr,
    output logic [core_pkg::data_width-1:0]    mem_wr_data,
    output logic                               mem_rd_req,
    output logic                               mem_wr_req,
    output logic [core_pkg::data_width-1:0]    out_data,
    output logic                               out_valid,
    output logic                               halt
);
    import core_pkg::*;

    seq_state_e state;
    // request out but not yet acked, keeps it up through ena low
    logic       req_pending;
    logic       mem_done;
    logic       is_store;
    logic       store_out;
    logic       store_halt;

    assign is_store   = (dec.opcode == STORE);
    assign store_out  = is_store && (mem_addr_calc == out_addr);
    assign store_halt = is_store && (mem_addr_calc == halt_addr);

    // new requests need ena, held ones do not
    assign mem_rd_req = (ena || req_pending) &&
                        ((state == FETCH) || ((state == MEM) && (dec.opcode == LOAD)));
    assign mem_wr_req = (ena || req_pending) && (state == MEM) && is_store;
    // rs1, rs2 and the instruction do not change while MEM waits
    assign mem_addr    = (state == FETCH) ? pc : mem_addr_calc;
    assign mem_wr_data = rs2_data;
    assign mem_done    = (mem_rd_req || mem_wr_req) && mem_ack;

    // output port pulse in the exec cycle itself
    assign out_valid = ena && (state == EXEC) && !dec.illegal && store_out;
    assign out_data  = rs2_data;
    assign halt      = (state == HALTED);

    // write-back, alu result in EXEC or load data in the ack cycle
    assign rf_wr_sel  = dec.rd_sel;
    assign rf_wr_data = (state == MEM) ? mem_rd_data : result;

    always_comb begin
        rf_wr_en = 1'b0;
        if ((state == EXEC) && ena && !dec.illegal) begin
            rf_wr_en = !(dec.opcode inside {LOAD, STORE, BRANCH});
        end else if ((state == MEM) && mem_done) begin
            rf_wr_en = (dec.opcode == LOAD);
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= FETCH;
            pc          <= reset_pc;
            req_pending <= 1'b0;
        end else begin
            req_pending <= (mem_rd_req || mem_wr_req) && !mem_ack;
            case (state)
                FETCH: begin
                    if (mem_done) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (ena) begin
                        if (dec.illegal || store_halt) begin
                            state <= HALTED;
                        end else if ((dec.opcode == LOAD) || (is_store && !store_out)) begin
                            state <= MEM;
                        end else begin
                            state <= FETCH;
                            pc    <= next_pc;
                        end
                    end
                end
                MEM: begin
                    // next_pc is still pc+4 for loads and stores
                    if (mem_done) begin
                        state <= FETCH;
                        pc    <= next_pc;
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // instruction register, loaded on the fetch ack
    always_ff @(posedge clk) begin
        if ((state == FETCH) && mem_done) begin
            instr <= mem_rd_data;
        end
    end

    // one request at a time on the shared port
    one_req: assert property (@(posedge clk) disable iff (!rst)
        !(mem_rd_req && mem_wr_req));

    // request, direction and address hold until acked
    req_held: assert property (@(posedge clk) disable iff (!rst)
        (mem_rd_req || mem_wr_req) && !mem_ack |=> $stable({mem_rd_req, mem_wr_req, mem_addr}));

    // only reset leaves HALTED
    halt_sticky: assert property (@(posedge clk) disable iff (!rst)
        halt |=> halt);

endmodule

`default_nettype wire

//--- rtl/core_top.sv
// rv32i multi-cycle core top level, one word-wide memory port plus output and halt
`timescale 1ns/1ps
`default_nettype none

module core_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            ena,
    input  logic [core_pkg::data_width-1:0] mem_rd_data,
    input  logic                            mem_ack,
    output logic [core_pkg::addr_width-1:0] mem_addr,
    output logic [core_pkg::data_width-1:0] mem_wr_data,
    output logic                            mem_rd_req,
    output logic                            mem_wr_req,
    output logic [core_pkg::data_width-1:0] out_data,
    output logic                            out_valid,
    output logic                            halt
);
    import core_pkg::*;

    logic [addr_width-1:0]    pc;
    logic [data_width-1:0]    instr;
    logic [data_width-1:0]    rs1_data;
    logic [data_width-1:0]    rs2_data;
    logic                     rf_wr_en;
    logic [reg_sel_width-1:0] rf_wr_sel;
    logic [data_width-1:0]    rf_wr_data;
    logic [data_width-1:0]    result;
    logic [addr_width-1:0]    next_pc;
    logic [addr_width-1:0]    mem_addr_calc;

    decoded_if dec_if ();

    instr_decode u_decode (
        .instr (instr),
        .dec   (dec_if.decoder)
    );

    // register selects come straight off the decoder
    reg_file u_regs (
        .clk      (clk),
        .rst      (rst),
        .rs1_sel  (dec_if.rs1_sel),
        .rs2_sel  (dec_if.rs2_sel),
        .wr_en    (rf_wr_en),
        .wr_sel   (rf_wr_sel),
        .wr_data  (rf_wr_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    // branch_taken is folded into next_pc already
    exec_unit u_exec (
        .pc            (pc),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .dec           (dec_if.exec),
        .result        (result),
        .branch_taken  (),
        .next_pc       (next_pc),
        .mem_addr_calc (mem_addr_calc)
    );

    core_sequencer u_seq (
        .clk           (clk),
        .rst           (rst),
        .ena           (ena),
        .mem_rd_data   (mem_rd_data),
        .mem_ack       (mem_ack),
        .result        (result),
        .next_pc       (next_pc),
        .mem_addr_calc (mem_addr_calc),
        .rs2_data      (rs2_data),
        .dec           (dec_if.seq),
        .pc            (pc),
        .instr         (instr),
        .rf_wr_en      (rf_wr_en),
        .rf_wr_sel     (rf_wr_sel),
        .rf_wr_data    (rf_wr_data),
        .mem_addr      (mem_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_rd_req    (mem_rd_req),
        .mem_wr_req    (mem_wr_req),
        .out_data      (out_data),
        .out_valid     (out_valid),
        .halt          (halt)
    );

endmodule

`default_nettype wire

//--- rtl/decoded_if.sv
// decoded instruction fields, driven by the decoder and read by execute and sequencer
`timescale 1ns/1ps
`default_nettype none

interface decoded_if;
    import core_pkg::*;

    opcode_e                  opcode;
    alu_op_e                  alu_op;
    // branch condition select
    logic [2:0]               funct3;
    logic [reg_sel_width-1:0] rd_sel;
    logic [reg_sel_width-1:0] rs1_sel;
    logic [reg_sel_width-1:0] rs2_sel;
    // sign-extended, already in final position
    logic [data_width-1:0]    imm;
    // unknown opcode or function
    logic                     illegal;

    modport decoder (
        output opcode, alu_op, funct3, rd_sel, rs1_sel, rs2_sel, imm, illegal
    );

    modport exec (
        input alu_op, opcode, funct3, imm
    );

    modport seq (
        input opcode, rd_sel, illegal
    );

endinterface

`default_nettype wire

//--- rtl/exec_unit.sv
// combinational execute stage: alu result, branch decision, next pc and load/store address
`timescale 1ns/1ps
`default_nettype none

module exec_unit (
    input  logic [core_pkg::addr_width-1:0] pc,
    input  logic [core_pkg::data_width-1:0] rs1_data,
    input  logic [core_pkg::data_width-1:0] rs2_data,
    decoded_if.exec                         dec,
    output logic [core_pkg::data_width-1:0] result,
    output logic                            branch_taken,
    output logic [core_pkg::addr_width-1:0] next_pc,
    output logic [core_pkg::addr_width-1:0] mem_addr_calc
);
    import core_pkg::*;

    logic [data_width-1:0] op_b;
    logic [4:0]            shamt;
    logic [data_width-1:0] alu_out;
    logic [addr_width-1:0] pc_plus4;
    logic [addr_width-1:0] pc_plus_imm;
    logic                  cond;

    // register operand only for OP, immediate for everything else
    assign op_b  = (dec.opcode == OP) ? rs2_data : dec.imm;
    // for slli/srli this is the shamt field of the immediate
    assign shamt = op_b[4:0];

    assign pc_plus4      = pc + 32'd4;
    assign pc_plus_imm   = pc + dec.imm;
    assign mem_addr_calc = rs1_data + dec.imm;

    always_comb begin
        case (dec.alu_op)
            ALU_ADD:  alu_out = rs1_data + op_b;
            ALU_SUB:  alu_out = rs1_data - op_b;
            ALU_SLT:  alu_out = {{(data_width-1){1'b0}}, $signed(rs1_data) < $signed(op_b)};
            ALU_SLTU: alu_out = {{(data_width-1){1'b0}}, rs1_data < op_b};
            ALU_AND:  alu_out = rs1_data & op_b;
            ALU_OR:   alu_out = rs1_data | op_b;
            ALU_XOR:  alu_out = rs1_data ^ op_b;
            ALU_SLL:  alu_out = rs1_data << shamt;
            ALU_SRL:  alu_out = rs1_data >> shamt;
            ALU_SRA:  alu_out = $signed(rs1_data) >>> shamt;
            ALU_PASS: alu_out = dec.imm;
            default:  alu_out = rs1_data + op_b;
        endcase
    end

    // branch compare always on the two registers
    always_comb begin
        case (dec.funct3)
            3'b000:  cond = (rs1_data == rs2_data);
            3'b001:  cond = (rs1_data != rs2_data);
            3'b100:  cond = ($signed(rs1_data) < $signed(rs2_data));
            3'b101:  cond = ($signed(rs1_data) >= $signed(rs2_data));
            3'b110:  cond = (rs1_data < rs2_data);
            3'b111:  cond = (rs1_data >= rs2_data);
            default: cond = 1'b0;
        endcase
    end

    assign branch_taken = (dec.opcode == BRANCH) && cond;

    always_comb begin
        result  = alu_out;
        next_pc = pc_plus4;
        case (dec.opcode)
            AUIPC: result = pc_plus_imm;
            JAL: begin
                // link value, then jump relative to pc
                result  = pc_plus4;
                next_pc = pc_plus_imm;
            end
            JALR: begin
                result  = pc_plus4;
                // target low bit cleared
                next_pc = {mem_addr_calc[addr_width-1:1], 1'b0};
            end
            BRANCH: begin
                if (branch_taken) begin
                    next_pc = pc_plus_imm;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/instr_decode.sv
// combinational rv32i decoder, splits the latched instruction into fields and immediate
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
    input  logic [core_pkg::data_width-1:0] instr,
    decoded_if.decoder                      dec
);
    import core_pkg::*;

    logic [6:0]            funct7;
    logic [2:0]            funct3;
    logic [data_width-1:0] imm_i;
    logic [data_width-1:0] imm_s;
    logic [data_width-1:0] imm_b;
    logic [data_width-1:0] imm_u;
    logic [data_width-1:0] imm_j;

    assign funct7 = instr[31:25];
    assign funct3 = instr[14:12];

    // fixed field positions
    assign dec.opcode  = opcode_e'(instr[6:0]);
    assign dec.funct3  = funct3;
    assign dec.rd_sel  = instr[11:7];
    assign dec.rs1_sel = instr[19:15];
    assign dec.rs2_sel = instr[24:20];

    // immediate formats, sign bit is always instr[31]
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        // i-type and add cover loads, jalr, auipc and jal
        dec.imm     = imm_i;
        dec.alu_op  = ALU_ADD;
        dec.illegal = 1'b0;
        case (dec.opcode)
            OPIMM: begin
                case (funct3)
                    3'b000: dec.alu_op = ALU_ADD;
                    3'b010: dec.alu_op = ALU_SLT;
                    3'b011: dec.alu_op = ALU_SLTU;
                    3'b100: dec.alu_op = ALU_XOR;
                    3'b110: dec.alu_op = ALU_OR;
                    3'b111: dec.alu_op = ALU_AND;
                    3'b001: begin
                        dec.alu_op  = ALU_SLL;
                        dec.illegal = (funct7 != 7'b0);
                    end
                    default: begin
                        // srli only, srai is not part of this core
                        dec.alu_op  = ALU_SRL;
                        dec.illegal = (funct7 != 7'b0);
                    end
                endcase
            end
            OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = ALU_ADD;
                    10'b0100000_000: dec.alu_op = ALU_SUB;
                    10'b0000000_010: dec.alu_op = ALU_SLT;
                    10'b0000000_011: dec.alu_op = ALU_SLTU;
                    10'b0000000_111: dec.alu_op = ALU_AND;
                    10'b0000000_110: dec.alu_op = ALU_OR;
                    10'b0000000_100: dec.alu_op = ALU_XOR;
                    10'b0000000_001: dec.alu_op = ALU_SLL;
                    10'b0000000_101: dec.alu_op = ALU_SRL;
                    10'b0100000_101: dec.alu_op = ALU_SRA;
                    default:         dec.illegal = 1'b1;
                endcase
            end
            // word access only
            LOAD: dec.illegal = (funct3 != 3'b010);
            STORE: begin
                dec.imm     = imm_s;
                dec.illegal = (funct3 != 3'b010);
            end
            BRANCH: begin
                dec.imm     = imm_b;
                // funct3 010 and 011 are unassigned
                dec.illegal = (funct3[2:1] == 2'b01);
            end
            LUI: begin
                dec.imm    = imm_u;
                dec.alu_op = ALU_PASS;
            end
            AUIPC: dec.imm = imm_u;
            JAL: dec.imm = imm_j;
            JALR: dec.illegal = (funct3 != 3'b000);
            default: dec.illegal = 1'b1;
        endcase
    end

    // every resolved opcode path assigns a real alu function
    always_comb begin
        if (!$isunknown(instr[6:0])) begin
            assert final (!$isunknown(dec.alu_op))
                else $error("alu_op unknown for opcode %b", instr[6:0]);
        end
    end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
// 32 x 32 register file, two combinational reads and one clocked write
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  logic                               clk,
    input  logic                               rst,
    input  logic [core_pkg::reg_sel_width-1:0] rs1_sel,
    input  logic [core_pkg::reg_sel_width-1:0] rs2_sel,
    input  logic                               wr_en,
    input  logic [core_pkg::reg_sel_width-1:0] wr_sel,
    input  logic [core_pkg::data_width-1:0]    wr_data,
    output logic [core_pkg::data_width-1:0]    rs1_data,
    output logic [core_pkg::data_width-1:0]    rs2_data
);
    import core_pkg::*;

    logic [data_width-1:0] regs [num_regs];

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int i = 0; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_sel != '0)) begin
            // x0 is never written
            regs[wr_sel] <= wr_data;
        end
    end

    // x0 reads as zero
    assign rs1_data = (rs1_sel == '0) ? '0 : regs[rs1_sel];
    assign rs2_data = (rs2_sel == '0) ? '0 : regs[rs2_sel];

    // sequencer must resolve rd before it enables a write
    wr_sel_known: assert property (@(posedge clk) disable iff (!rst)
        wr_en |-> !$isunknown(wr_sel));

endmodule

`default_nettype wire

//--- tb/tb_core.sv
// testbench top that runs the program in tb_mem on the core and checks every output word
`timescale 1ns/1ps
`default_nettype none

module tb_core;
    import core_pkg::*;

    localparam int reset_cycles   = 5;
    localparam int ena_low_cycles = 6;
    localparam int drain_cycles   = 20;
    // longest ack delay of the memory model
    localparam int max_wait       = 3;

    logic                  clk;
    logic                  rst;
    logic                  ena;
    logic [data_width-1:0] mem_rd_data;
    logic                  mem_ack;
    logic [addr_width-1:0] mem_addr;
    logic [data_width-1:0] mem_wr_data;
    logic                  mem_rd_req;
    logic                  mem_wr_req;
    logic [data_width-1:0] out_data;
    logic                  out_valid;
    logic                  halt;
    int                    prog_words;

    logic [data_width-1:0] expected [$];
    string test_name [6] = '{"arithmetic and immediates", "branches", "jumps", "memory",
                             "register x0", "halt and enable"};
    // index of the last output word of each output test
    int test_last [5] = '{10, 16, 18, 20, 21};
    int out_count     = 0;
    int fail_count    = 0;
    int test_idx      = 0;
    int test_base     = 0;
    int tests_passed  = 0;
    int tests_failed  = 0;
    int cycles        = 0;

    core_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .ena         (ena),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .out_data    (out_data),
        .out_valid   (out_valid),
        .halt        (halt)
    );

    tb_mem u_mem (
        .clk        (clk),
        .rst        (rst),
        .addr       (mem_addr),
        .wr_data    (mem_wr_data),
        .rd_req     (mem_rd_req),
        .wr_req     (mem_wr_req),
        .rd_data    (mem_rd_data),
        .ack        (mem_ack),
        .prog_words (prog_words)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_test();
        int errs;
        errs = fail_count - test_base;
        $display("test %0d %s: %s", test_idx + 1, test_name[test_idx],
                 errs == 0 ? "ok" : "failed");
        if (errs == 0) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        test_idx++;
        test_base = fail_count;
    endtask

    // compare each output word in order
    always @(posedge clk) begin
        if (rst && out_valid) begin
            if (out_count >= expected.size()) begin
                $display("unexpected extra output %h at %0t", out_data, $time);
                fail_count++;
            end else begin
                out_match: assert (out_data === expected[out_count])
                else begin
                    $display("[ERROR] %0t out_data: got %h, expected %h",
                             $time, out_data, expected[out_count]);
                    fail_count++;
                end
                if ((test_idx < 5) && (out_count == test_last[test_idx])) begin
                    report_test();
                end
            end
            out_count++;
        end
    end

    // request and address hold until ack
    req_hold: assert property (@(posedge clk) disable iff (!rst)
        (mem_rd_req || mem_wr_req) && !mem_ack |=> $stable({mem_rd_req, mem_wr_req, mem_addr}))
    else begin
        $display("memory request changed before ack at %0t", $time);
        fail_count++;
    end

    // store data also holds
    wr_data_hold: assert property (@(posedge clk) disable iff (!rst)
        mem_wr_req && !mem_ack |=> $stable(mem_wr_data))
    else begin
        $display("store data changed before ack at %0t", $time);
        fail_count++;
    end

    // with ena low only an already raised request may be seen
    paused_quiet: assert property (@(posedge clk) disable iff (!rst)
        (mem_rd_req || mem_wr_req) && !ena |-> $past((mem_rd_req || mem_wr_req) && !mem_ack))
    else begin
        $display("new memory request while ena was low at %0t", $time);
        fail_count++;
    end

    halt_quiet: assert property (@(posedge clk) disable iff (!rst)
        halt |-> !(mem_rd_req || mem_wr_req))
    else begin
        $display("memory request after halt at %0t", $time);
        fail_count++;
    end

    halt_stays: assert property (@(posedge clk) disable iff (!rst)
        halt |=> halt)
    else begin
        $display("halt fell without reset at %0t", $time);
        fail_count++;
    end

    // limit from program length and worst case per instruction
    always @(posedge clk) begin
        cycles++;
        if (cycles > prog_words * (2 + 2 * max_wait) * 2 + reset_cycles + ena_low_cycles
                     + drain_cycles) begin
            $display("timeout: core did not halt within %0d cycles", cycles);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    initial begin
        rst <= 1'b0;
        ena <= 1'b0;
        expected = '{
            // sub, slt, sltu, xori, or, andi
            32'd107, 32'd1, 32'd0, 32'h0000_0094, 32'hffff_fffd, 32'h0000_003c,
            // slli, srli, sra, lui, auipc at 232
            32'h0000_0640, 32'h0000_000f, 32'hffff_fffe, 32'h1234_5000, 32'd4328,
            // not-taken markers beq .. bgeu
            32'd100, 32'd107, 32'h0000_0094, 32'h0000_0640, 32'h0000_000f, 32'h1234_5000,
            // jal link 336+4, jalr link 352+4
            32'd340, 32'd356,
            // loads after stores
            32'hffff_fffd, 32'h0000_0640,
            // x0
            32'd0
        };
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b1;
        ena <= 1'b1;
        // ena drops on the edge leaving the exec cycle of an output store
        // the following fetch has to wait paused without raising a request
        wait (out_count >= 12);
        ena <= 1'b0;
        repeat (ena_low_cycles) @(posedge clk);
        ena <= 1'b1;
        wait (halt);
        repeat (drain_cycles) @(posedge clk);
        if (out_count != expected.size()) begin
            $display("output count wrong: %0d seen, %0d expected", out_count, expected.size());
            fail_count++;
        end
        if (!halt) begin
            $display("halt is low after the drain cycles");
            fail_count++;
        end
        test_idx = 5;
        report_test();
        $display("tests passed %0d, failed %0d, outputs %0d of %0d, errors %0d",
                 tests_passed, tests_failed, out_count, expected.size(), fail_count);
        if ((fail_count == 0) && (tests_passed == 6)) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/tb_mem.sv
// test memory for the core: program image from reset_pc on, data words, randomly delayed ack
`timescale 1ns/1ps
`default_nettype none

module tb_mem (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [core_pkg::addr_width-1:0] addr,
    input  logic [core_pkg::data_width-1:0] wr_data,
    input  logic                            rd_req,
    input  logic                            wr_req,
    output logic [core_pkg::data_width-1:0] rd_data,
    output logic                            ack,
    output int                              prog_words
);
    import core_pkg::*;

    // 1 KB, byte address bits 9:2 select the word
    logic [data_width-1:0] mem [256];
    int                    load_ptr;

    // rv32i encoders, fields in ISA bit order
    function automatic logic [31:0] alu_imm(logic [2:0] f3, logic [4:0] rd, logic [4:0] rs1,
                                            logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] alu_reg(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                            logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] load_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic logic [31:0] store_word(logic [4:0] rs2, logic [4:0] rs1,
                                               logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    // branch offset is relative to the branch itself
    function automatic logic [31:0] branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2,
                                           logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    // lui 0110111, auipc 0010111
    function automatic logic [31:0] upper(logic [6:0] op, logic [4:0] rd, logic [19:0] imm);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] jal_to(logic [4:0] rd, logic [20:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_to(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    task automatic place(input logic [31:0] word);
        mem[load_ptr] = word;
        load_ptr++;
    endtask

    // x31 holds out_addr once the program has started
    task automatic show(input logic [4:0] rs2);
        place(store_word(rs2, 31, 12'd0));
    endtask

    initial begin
        int waited;
        int delay;
        ack     = 1'b0;
        rd_data = '0;
        // fill carries the byte address so a stray read is easy to spot
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hf111_0000 | (i << 2);
        end
        load_ptr = reset_pc >> 2;
        // 128: x31 = out_addr, x30 = marker for wrong paths, base operands
        place(upper(7'b0110111, 31, 20'h000f4));
        place(alu_imm(3'b000, 31, 31, 12'd576));
        place(alu_imm(3'b000, 30, 0, 12'h7ba));
        place(alu_imm(3'b000, 1, 0, 12'd100));
        place(alu_imm(3'b000, 2, 0, 12'hff9));
        // 148: arithmetic, logic and shifts
        place(alu_reg(7'b0100000, 3'b000, 3, 1, 2));
        show(3);
        place(alu_reg(7'b0000000, 3'b010, 4, 2, 1));
        show(4);
        place(alu_reg(7'b0000000, 3'b011, 5, 2, 1));
        show(5);
        place(alu_imm(3'b100, 6, 1, 12'h0f0));
        show(6);
        place(alu_reg(7'b0000000, 3'b110, 7, 6, 2));
        show(7);
        place(alu_imm(3'b111, 8, 7, 12'h03c));
        show(8);
        place(alu_imm(3'b001, 9, 1, 12'd4));
        show(9);
        place(alu_imm(3'b101, 10, 2, 12'd28));
        show(10);
        place(alu_imm(3'b000, 13, 0, 12'd2));
        place(alu_reg(7'b0100000, 3'b101, 11, 2, 13));
        show(11);
        place(upper(7'b0110111, 12, 20'h12345));
        show(12);
        // 232: auipc
        place(upper(7'b0010111, 14, 20'h00001));
        show(14);
        // 240: each condition taken over a wrong-path store, then not taken into a marker
        place(branch(3'b000, 1, 1, 13'd8));
        show(30);
        place(branch(3'b000, 1, 2, 13'd8));
        show(1);
        place(branch(3'b001, 1, 2, 13'd8));
        show(30);
        place(branch(3'b001, 1, 1, 13'd8));
        show(3);
        place(branch(3'b100, 2, 1, 13'd8));
        show(30);
        place(branch(3'b100, 1, 2, 13'd8));
        show(6);
        place(branch(3'b101, 1, 2, 13'd8));
        show(30);
        place(branch(3'b101, 2, 1, 13'd8));
        show(9);
        place(branch(3'b110, 1, 2, 13'd8));
        show(30);
        place(branch(3'b110, 2, 1, 13'd8));
        show(10);
        place(branch(3'b111, 2, 1, 13'd8));
        show(30);
        place(branch(3'b111, 1, 2, 13'd8));
        show(12);
        // 336: jal over one store, 348: jalr with odd offset lands on 360
        place(jal_to(16, 21'd8));
        show(30);
        show(16);
        place(upper(7'b0010111, 17, 20'h00000));
        place(jalr_to(18, 17, 12'd13));
        show(30);
        show(18);
        // 364: store then load back at 512 and 508
        place(alu_imm(3'b000, 19, 0, 12'd512));
        place(store_word(7, 19, 12'd0));
        place(load_word(20, 19, 12'd0));
        show(20);
        place(store_word(9, 19, 12'hffc));
        place(load_word(21, 19, 12'hffc));
        show(21);
        // 392: write to x0 is dropped
        place(alu_imm(3'b000, 0, 0, 12'd55));
        show(0);
        // 400: store to halt_addr
        place(store_word(0, 31, 12'd4));
        prog_words = load_ptr - (reset_pc >> 2);

        void'($urandom(32'h727f));
        waited = 0;
        delay  = $urandom % 4;
        forever begin
            @(posedge clk);
            if (!rst) begin
                ack    <= 1'b0;
                waited = 0;
            end else if (ack) begin
                // access completes on this edge
                if (wr_req) begin
                    mem[addr[9:2]] = wr_data;
                end
                ack    <= 1'b0;
                waited = 0;
                delay  = $urandom % 4;
            end else if (rd_req || wr_req) begin
                if (waited == delay) begin
                    ack     <= 1'b1;
                    rd_data <= mem[addr[9:2]];
                end else begin
                    waited++;
                end
            end
        end
    end

endmodule

`default_nettype wire
